/* logic/axil_mon_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared definitions for the AXI4-Lite protocol monitor
// Violation bit indices, register offsets, response codes
// Vector types for violations, timers, counts and the config port
//////////////////////////////////////////////////////////////////////
package axil_mon_pkg;

	// Number of violation kinds tracked in STATUS
	localparam int NUM_VIOL = 12;

	// One bit per violation kind
	typedef logic [NUM_VIOL-1:0] viol_t;

	// Limit or stall/delay timer
	typedef logic [7:0] timer_t;

	// One outstanding-count field of the COUNTS register
	typedef logic [3:0] cnt_field_t;

	// AXI response code
	typedef logic [1:0] resp_t;

	// Configuration port word and offset
	typedef logic [31:0] cfg_data_t;
	typedef logic [3:0]  cfg_addr_t;

	//////////////////////////////////////////////////////////////////////
	// Violation bit positions
	//////////////////////////////////////////////////////////////////////
	localparam int VIOL_AW_STALL  = 0;
	localparam int VIOL_W_STALL   = 1;
	localparam int VIOL_AR_STALL  = 2;
	localparam int VIOL_B_STALL   = 3;
	localparam int VIOL_R_STALL   = 4;
	localparam int VIOL_WR_LAT    = 5;
	localparam int VIOL_RD_LAT    = 6;
	localparam int VIOL_REQ_STAB  = 7;
	localparam int VIOL_RESP_STAB = 8;
	localparam int VIOL_ORPHAN    = 9;
	localparam int VIOL_OVERFLOW  = 10;
	localparam int VIOL_EXOKAY    = 11;

	// Register map of the configuration port
	localparam cfg_addr_t REG_CTRL   = 4'h0;
	localparam cfg_addr_t REG_LIMITS = 4'h4;
	localparam cfg_addr_t REG_STATUS = 4'h8;
	localparam cfg_addr_t REG_COUNTS = 4'hC;

	// Response codes
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_EXOKAY = 2'b01;

	// Reset value of every limit
	localparam timer_t DEF_LIMIT = 8'd8;

endpackage

/* logic/axil_txn_counter.sv */
//////////////////////////////////////////////////////////////////////
// Outstanding request counters for a monitored AXI4-Lite bus
// Flags orphan responses and counter overflow
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_txn_counter #(
	parameter int DEPTH_WIDTH = 4
) (
	input  logic                   i_clk,
	input  logic                   i_axi_reset_n,
	input  logic                   i_mon_awvalid,
	input  logic                   i_mon_awready,
	input  logic                   i_mon_wvalid,
	input  logic                   i_mon_wready,
	input  logic                   i_mon_bvalid,
	input  logic                   i_mon_bready,
	input  logic                   i_mon_arvalid,
	input  logic                   i_mon_arready,
	input  logic                   i_mon_rvalid,
	input  logic                   i_mon_rready,
	output logic [DEPTH_WIDTH-1:0] o_awr_cnt,
	output logic [DEPTH_WIDTH-1:0] o_wr_cnt,
	output logic [DEPTH_WIDTH-1:0] o_rd_cnt,
	output axil_mon_pkg::viol_t    o_viol
);
	import axil_mon_pkg::*;

	logic [DEPTH_WIDTH-1:0] awr_next, wr_next, rd_next;
	logic awr_ovf, wr_ovf, rd_ovf;
	logic awr_orph, wr_orph, rd_orph;

	// Next count plus overflow and orphan flags, packed as {ovf, orph, count}
	function automatic logic [DEPTH_WIDTH+1:0] count_step(
		input logic [DEPTH_WIDTH-1:0] cnt,
		input logic                   req_fire,
		input logic                   rsp_valid,
		input logic                   rsp_fire
	);
		logic dec;
		logic ovf;
		logic orph;
		logic [DEPTH_WIDTH-1:0] nxt;
		// A response with nothing pending never decrements
		orph = rsp_valid && (cnt == '0);
		dec  = rsp_fire && (cnt != '0);
		// Saturate instead of wrapping
		ovf  = req_fire && !dec && (cnt == '1);
		nxt  = cnt;
		if (req_fire && !dec && !ovf)
			nxt = cnt + 1'b1;
		else if (dec && !req_fire)
			nxt = cnt - 1'b1;
		return {ovf, orph, nxt};
	endfunction

	// B retires one address and one data beat
	always_comb
	begin
		{awr_ovf, awr_orph, awr_next} = count_step(o_awr_cnt,
			i_mon_awvalid && i_mon_awready, i_mon_bvalid, i_mon_bvalid && i_mon_bready);
		{wr_ovf, wr_orph, wr_next} = count_step(o_wr_cnt,
			i_mon_wvalid && i_mon_wready, i_mon_bvalid, i_mon_bvalid && i_mon_bready);
		{rd_ovf, rd_orph, rd_next} = count_step(o_rd_cnt,
			i_mon_arvalid && i_mon_arready, i_mon_rvalid, i_mon_rvalid && i_mon_rready);
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_awr_cnt <= '0;
			o_wr_cnt  <= '0;
			o_rd_cnt  <= '0;
			o_viol    <= '0;
		end
		else
		begin
			o_awr_cnt <= awr_next;
			o_wr_cnt  <= wr_next;
			o_rd_cnt  <= rd_next;
			// One-cycle pulses
			o_viol                <= '0;
			o_viol[VIOL_ORPHAN]   <= awr_orph || wr_orph || rd_orph;
			o_viol[VIOL_OVERFLOW] <= awr_ovf || wr_ovf || rd_ovf;
		end
	end

endmodule

/* logic/axil_stall_checker.sv */
//////////////////////////////////////////////////////////////////////
// Request stall, response stall and response latency timers
// Each timer pulses its violation bit when it reaches its limit
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_stall_checker #(
	parameter int DEPTH_WIDTH = 4
) (
	input  logic                   i_clk,
	input  logic                   i_axi_reset_n,
	input  logic                   i_enable,
	input  logic                   i_mon_awvalid,
	input  logic                   i_mon_awready,
	input  logic                   i_mon_wvalid,
	input  logic                   i_mon_wready,
	input  logic                   i_mon_bvalid,
	input  logic                   i_mon_bready,
	input  logic                   i_mon_arvalid,
	input  logic                   i_mon_arready,
	input  logic                   i_mon_rvalid,
	input  logic                   i_mon_rready,
	input  logic [DEPTH_WIDTH-1:0] i_awr_cnt,
	input  logic [DEPTH_WIDTH-1:0] i_wr_cnt,
	input  logic [DEPTH_WIDTH-1:0] i_rd_cnt,
	input  axil_mon_pkg::timer_t   i_req_limit,
	input  axil_mon_pkg::timer_t   i_resp_limit,
	input  axil_mon_pkg::timer_t   i_delay_limit,
	output axil_mon_pkg::viol_t    o_viol
);
	import axil_mon_pkg::*;

	// Timer index matches its violation bit
	localparam int NUM_TMR = 7;

	logic [NUM_TMR-1:0] cond;
	timer_t             tmr [NUM_TMR];
	timer_t             lim [NUM_TMR];

	//////////////////////////////////////////////////////////////////////
	// Counting conditions
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		// A pending B backs up the write channels, so no stall counted
		cond[VIOL_AW_STALL] = i_mon_awvalid && !i_mon_awready && !i_mon_bvalid
			&& !(!i_mon_wvalid && (i_awr_cnt >= i_wr_cnt));
		cond[VIOL_W_STALL]  = i_mon_wvalid && !i_mon_wready && !i_mon_bvalid
			&& !(!i_mon_awvalid && (i_wr_cnt >= i_awr_cnt));
		cond[VIOL_AR_STALL] = i_mon_arvalid && !i_mon_arready && !i_mon_rvalid;
		// Master holding off a response
		cond[VIOL_B_STALL]  = i_mon_bvalid && !i_mon_bready;
		cond[VIOL_R_STALL]  = i_mon_rvalid && !i_mon_rready;
		// Slave sitting on a complete request
		cond[VIOL_WR_LAT]   = (i_awr_cnt != '0) && (i_wr_cnt != '0) && !i_mon_bvalid;
		cond[VIOL_RD_LAT]   = (i_rd_cnt != '0) && !i_mon_rvalid;
		// Disabled monitor keeps every timer idle
		if (!i_enable)
			cond = '0;
	end

	// Limit per timer
	always_comb
	begin
		lim[VIOL_AW_STALL] = i_req_limit;
		lim[VIOL_W_STALL]  = i_req_limit;
		lim[VIOL_AR_STALL] = i_req_limit;
		lim[VIOL_B_STALL]  = i_resp_limit;
		lim[VIOL_R_STALL]  = i_resp_limit;
		lim[VIOL_WR_LAT]   = i_delay_limit;
		lim[VIOL_RD_LAT]   = i_delay_limit;
	end

	//////////////////////////////////////////////////////////////////////
	// Timers and pulses
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			for (int i = 0; i < NUM_TMR; i++)
				tmr[i] <= '0;
			o_viol <= '0;
		end
		else
		begin
			o_viol <= '0;
			for (int i = 0; i < NUM_TMR; i++)
			begin
				// Saturating count while the condition lasts
				if (!cond[i])
					tmr[i] <= '0;
				else if (tmr[i] != '1)
					tmr[i] <= tmr[i] + 1'b1;
				// Fires once, on the cycle the limit is reached; zero limit disables
				if (cond[i] && (lim[i] != '0) && (tmr[i] == lim[i] - 1'b1))
					o_viol[i] <= 1'b1;
			end
		end
	end

endmodule

/* logic/axil_stability_checker.sv */
//////////////////////////////////////////////////////////////////////
// Valid and payload stability check on all five channels
// Also flags the exclusive-okay response code
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_stability_checker #(
	parameter int ADDR_WIDTH = 28,
	parameter int DATA_WIDTH = 32
) (
	input  logic                    i_clk,
	input  logic                    i_axi_reset_n,
	input  logic [ADDR_WIDTH-1:0]   i_mon_awaddr,
	input  logic                    i_mon_awvalid,
	input  logic                    i_mon_awready,
	input  logic [DATA_WIDTH-1:0]   i_mon_wdata,
	input  logic [DATA_WIDTH/8-1:0] i_mon_wstrb,
	input  logic                    i_mon_wvalid,
	input  logic                    i_mon_wready,
	input  logic [ADDR_WIDTH-1:0]   i_mon_araddr,
	input  logic                    i_mon_arvalid,
	input  logic                    i_mon_arready,
	input  axil_mon_pkg::resp_t     i_mon_bresp,
	input  logic                    i_mon_bvalid,
	input  logic                    i_mon_bready,
	input  axil_mon_pkg::resp_t     i_mon_rresp,
	input  logic [DATA_WIDTH-1:0]   i_mon_rdata,
	input  logic                    i_mon_rvalid,
	input  logic                    i_mon_rready,
	output axil_mon_pkg::viol_t     o_viol
);
	import axil_mon_pkg::*;

	// Stalled on the previous cycle
	logic aw_held, w_held, ar_held, b_held, r_held;

	// Payload captured on the previous cycle
	logic [ADDR_WIDTH-1:0]   awaddr_q, araddr_q;
	logic [DATA_WIDTH-1:0]   wdata_q, rdata_q;
	logic [DATA_WIDTH/8-1:0] wstrb_q;
	resp_t                   bresp_q, rresp_q;

	logic req_bad, resp_bad, exokay;

	// Held channel that dropped valid or moved its payload
	always_comb
	begin
		req_bad = (aw_held && (!i_mon_awvalid || (i_mon_awaddr != awaddr_q)))
			|| (w_held && (!i_mon_wvalid || (i_mon_wdata != wdata_q)
			|| (i_mon_wstrb != wstrb_q)))
			|| (ar_held && (!i_mon_arvalid || (i_mon_araddr != araddr_q)));
		resp_bad = (b_held && (!i_mon_bvalid || (i_mon_bresp != bresp_q)))
			|| (r_held && (!i_mon_rvalid || (i_mon_rresp != rresp_q)
			|| (i_mon_rdata != rdata_q)));
		exokay = (i_mon_bvalid && (i_mon_bresp == RESP_EXOKAY))
			|| (i_mon_rvalid && (i_mon_rresp == RESP_EXOKAY));
	end

	// Payload copies
	always_ff @(posedge i_clk)
	begin
		awaddr_q <= i_mon_awaddr;
		wdata_q  <= i_mon_wdata;
		wstrb_q  <= i_mon_wstrb;
		araddr_q <= i_mon_araddr;
		bresp_q  <= i_mon_bresp;
		rresp_q  <= i_mon_rresp;
		rdata_q  <= i_mon_rdata;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			{aw_held, w_held, ar_held, b_held, r_held} <= '0;
			o_viol <= '0;
		end
		else
		begin
			aw_held <= i_mon_awvalid && !i_mon_awready;
			w_held  <= i_mon_wvalid && !i_mon_wready;
			ar_held <= i_mon_arvalid && !i_mon_arready;
			b_held  <= i_mon_bvalid && !i_mon_bready;
			r_held  <= i_mon_rvalid && !i_mon_rready;
			o_viol                 <= '0;
			o_viol[VIOL_REQ_STAB]  <= req_bad;
			o_viol[VIOL_RESP_STAB] <= resp_bad;
			o_viol[VIOL_EXOKAY]    <= exokay;
		end
	end

endmodule

/* logic/axil_mon_regs.sv */
//////////////////////////////////////////////////////////////////////
// AXI4-Lite configuration slave of the protocol monitor
// Enable, limits, sticky violation status and count readback
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_mon_regs #(
	parameter int DEPTH_WIDTH = 4
) (
	input  logic                    i_clk,
	input  logic                    i_axi_reset_n,
	input  axil_mon_pkg::cfg_addr_t i_cfg_awaddr,
	input  logic                    i_cfg_awvalid,
	output logic                    o_cfg_awready,
	input  axil_mon_pkg::cfg_data_t i_cfg_wdata,
	input  logic [3:0]              i_cfg_wstrb,
	input  logic                    i_cfg_wvalid,
	output logic                    o_cfg_wready,
	output axil_mon_pkg::resp_t     o_cfg_bresp,
	output logic                    o_cfg_bvalid,
	input  logic                    i_cfg_bready,
	input  axil_mon_pkg::cfg_addr_t i_cfg_araddr,
	input  logic                    i_cfg_arvalid,
	output logic                    o_cfg_arready,
	output axil_mon_pkg::cfg_data_t o_cfg_rdata,
	output axil_mon_pkg::resp_t     o_cfg_rresp,
	output logic                    o_cfg_rvalid,
	input  logic                    i_cfg_rready,
	input  logic [DEPTH_WIDTH-1:0]  i_awr_cnt,
	input  logic [DEPTH_WIDTH-1:0]  i_wr_cnt,
	input  logic [DEPTH_WIDTH-1:0]  i_rd_cnt,
	input  axil_mon_pkg::viol_t     i_viol_cnt,
	input  axil_mon_pkg::viol_t     i_viol_stall,
	input  axil_mon_pkg::viol_t     i_viol_stab,
	output logic                    o_enable,
	output axil_mon_pkg::timer_t    o_req_limit,
	output axil_mon_pkg::timer_t    o_resp_limit,
	output axil_mon_pkg::timer_t    o_delay_limit,
	output logic                    o_viol_any
);
	import axil_mon_pkg::*;

	viol_t     status;
	viol_t     clr_mask;
	cfg_data_t byte_mask;
	cfg_data_t rd_mux;
	logic      wr_en, rd_en;

	// Handshake completes on the cycle the ready is up
	assign wr_en = o_cfg_awready && i_cfg_awvalid && i_cfg_wvalid;
	assign rd_en = o_cfg_arready && i_cfg_arvalid;

	// Never an error
	assign o_cfg_bresp = RESP_OKAY;
	assign o_cfg_rresp = RESP_OKAY;
	assign o_viol_any  = |status;

	//////////////////////////////////////////////////////////////////////
	// Bus handshake
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_cfg_awready <= 1'b0;
			o_cfg_wready  <= 1'b0;
			o_cfg_bvalid  <= 1'b0;
			o_cfg_arready <= 1'b0;
			o_cfg_rvalid  <= 1'b0;
		end
		else
		begin
			// Address and data accepted together, single-cycle ready
			o_cfg_awready <= i_cfg_awvalid && i_cfg_wvalid && !o_cfg_awready
				&& !o_cfg_bvalid;
			o_cfg_wready  <= i_cfg_awvalid && i_cfg_wvalid && !o_cfg_awready
				&& !o_cfg_bvalid;
			if (wr_en)
				o_cfg_bvalid <= 1'b1;
			else if (i_cfg_bready)
				o_cfg_bvalid <= 1'b0;
			// No new read while R is waiting
			o_cfg_arready <= i_cfg_arvalid && !o_cfg_arready && !o_cfg_rvalid;
			if (rd_en)
				o_cfg_rvalid <= 1'b1;
			else if (i_cfg_rready)
				o_cfg_rvalid <= 1'b0;
		end
	end

	// Read data register
	always_ff @(posedge i_clk)
	begin
		if (rd_en)
			o_cfg_rdata <= rd_mux;
	end

	// Register readback, unmapped reads as zero
	always_comb
	begin
		case (i_cfg_araddr)
		REG_CTRL:   rd_mux = {31'b0, o_enable};
		REG_LIMITS: rd_mux = {8'h00, o_delay_limit, o_resp_limit, o_req_limit};
		REG_STATUS: rd_mux = {{(32-NUM_VIOL){1'b0}}, status};
		REG_COUNTS: rd_mux = {20'h0, cnt_field_t'(i_wr_cnt), cnt_field_t'(i_awr_cnt),
			cnt_field_t'(i_rd_cnt)};
		default:    rd_mux = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control, limits and sticky status
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		byte_mask = {{8{i_cfg_wstrb[3]}}, {8{i_cfg_wstrb[2]}},
			{8{i_cfg_wstrb[1]}}, {8{i_cfg_wstrb[0]}}};
		// Write one to clear
		clr_mask = '0;
		if (wr_en && (i_cfg_awaddr == REG_STATUS))
			clr_mask = viol_t'(i_cfg_wdata & byte_mask);
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_enable      <= 1'b1;
			o_req_limit   <= DEF_LIMIT;
			o_resp_limit  <= DEF_LIMIT;
			o_delay_limit <= DEF_LIMIT;
			status        <= '0;
		end
		else
		begin
			if (wr_en && (i_cfg_awaddr == REG_CTRL) && i_cfg_wstrb[0])
				o_enable <= i_cfg_wdata[0];
			if (wr_en && (i_cfg_awaddr == REG_LIMITS))
			begin
				if (i_cfg_wstrb[0])
					o_req_limit <= i_cfg_wdata[7:0];
				if (i_cfg_wstrb[1])
					o_resp_limit <= i_cfg_wdata[15:8];
				if (i_cfg_wstrb[2])
					o_delay_limit <= i_cfg_wdata[23:16];
			end
			// A new pulse wins over a clear on the same cycle
			status <= (status & ~clr_mask)
				| (o_enable ? (i_viol_cnt | i_viol_stall | i_viol_stab) : '0);
		end
	end

endmodule

/* logic/axil_mon_top.sv */
//////////////////////////////////////////////////////////////////////
// AXI4-Lite protocol monitor top level
// Counter, stall and stability checkers plus the register block
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_mon_top #(
	parameter int DEPTH_WIDTH = 4,
	parameter int ADDR_WIDTH  = 28,
	parameter int DATA_WIDTH  = 32
) (
	input  logic                    i_clk,
	input  logic                    i_axi_reset_n,
	// Monitored bus, observed only
	input  logic [ADDR_WIDTH-1:0]   i_mon_awaddr,
	input  logic                    i_mon_awvalid,
	input  logic                    i_mon_awready,
	input  logic [DATA_WIDTH-1:0]   i_mon_wdata,
	input  logic [DATA_WIDTH/8-1:0] i_mon_wstrb,
	input  logic                    i_mon_wvalid,
	input  logic                    i_mon_wready,
	input  axil_mon_pkg::resp_t     i_mon_bresp,
	input  logic                    i_mon_bvalid,
	input  logic                    i_mon_bready,
	input  logic [ADDR_WIDTH-1:0]   i_mon_araddr,
	input  logic                    i_mon_arvalid,
	input  logic                    i_mon_arready,
	input  axil_mon_pkg::resp_t     i_mon_rresp,
	input  logic [DATA_WIDTH-1:0]   i_mon_rdata,
	input  logic                    i_mon_rvalid,
	input  logic                    i_mon_rready,
	// Configuration port
	input  axil_mon_pkg::cfg_addr_t i_cfg_awaddr,
	input  logic                    i_cfg_awvalid,
	output logic                    o_cfg_awready,
	input  axil_mon_pkg::cfg_data_t i_cfg_wdata,
	input  logic [3:0]              i_cfg_wstrb,
	input  logic                    i_cfg_wvalid,
	output logic                    o_cfg_wready,
	output axil_mon_pkg::resp_t     o_cfg_bresp,
	output logic                    o_cfg_bvalid,
	input  logic                    i_cfg_bready,
	input  axil_mon_pkg::cfg_addr_t i_cfg_araddr,
	input  logic                    i_cfg_arvalid,
	output logic                    o_cfg_arready,
	output axil_mon_pkg::cfg_data_t o_cfg_rdata,
	output axil_mon_pkg::resp_t     o_cfg_rresp,
	output logic                    o_cfg_rvalid,
	input  logic                    i_cfg_rready,
	output logic                    o_viol_any
);
	import axil_mon_pkg::*;

	logic [DEPTH_WIDTH-1:0] awr_cnt, wr_cnt, rd_cnt;
	viol_t                  viol_cnt, viol_stall, viol_stab;
	timer_t                 req_limit, resp_limit, delay_limit;
	logic                   enable;

	// Outstanding counts
	axil_txn_counter #(.DEPTH_WIDTH(DEPTH_WIDTH)) u_counter (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_mon_awvalid(i_mon_awvalid), .i_mon_awready(i_mon_awready),
		.i_mon_wvalid(i_mon_wvalid), .i_mon_wready(i_mon_wready),
		.i_mon_bvalid(i_mon_bvalid), .i_mon_bready(i_mon_bready),
		.i_mon_arvalid(i_mon_arvalid), .i_mon_arready(i_mon_arready),
		.i_mon_rvalid(i_mon_rvalid), .i_mon_rready(i_mon_rready),
		.o_awr_cnt(awr_cnt), .o_wr_cnt(wr_cnt), .o_rd_cnt(rd_cnt),
		.o_viol(viol_cnt)
	);

	// Stall and latency timers
	axil_stall_checker #(.DEPTH_WIDTH(DEPTH_WIDTH)) u_stall (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_enable(enable),
		.i_mon_awvalid(i_mon_awvalid), .i_mon_awready(i_mon_awready),
		.i_mon_wvalid(i_mon_wvalid), .i_mon_wready(i_mon_wready),
		.i_mon_bvalid(i_mon_bvalid), .i_mon_bready(i_mon_bready),
		.i_mon_arvalid(i_mon_arvalid), .i_mon_arready(i_mon_arready),
		.i_mon_rvalid(i_mon_rvalid), .i_mon_rready(i_mon_rready),
		.i_awr_cnt(awr_cnt), .i_wr_cnt(wr_cnt), .i_rd_cnt(rd_cnt),
		.i_req_limit(req_limit), .i_resp_limit(resp_limit),
		.i_delay_limit(delay_limit), .o_viol(viol_stall)
	);

	// Handshake stability and response code
	axil_stability_checker #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_stab (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_mon_awaddr(i_mon_awaddr), .i_mon_awvalid(i_mon_awvalid),
		.i_mon_awready(i_mon_awready), .i_mon_wdata(i_mon_wdata),
		.i_mon_wstrb(i_mon_wstrb), .i_mon_wvalid(i_mon_wvalid),
		.i_mon_wready(i_mon_wready), .i_mon_araddr(i_mon_araddr),
		.i_mon_arvalid(i_mon_arvalid), .i_mon_arready(i_mon_arready),
		.i_mon_bresp(i_mon_bresp), .i_mon_bvalid(i_mon_bvalid),
		.i_mon_bready(i_mon_bready), .i_mon_rresp(i_mon_rresp),
		.i_mon_rdata(i_mon_rdata), .i_mon_rvalid(i_mon_rvalid),
		.i_mon_rready(i_mon_rready), .o_viol(viol_stab)
	);

	// Configuration slave
	axil_mon_regs #(.DEPTH_WIDTH(DEPTH_WIDTH)) u_regs (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_cfg_awaddr(i_cfg_awaddr), .i_cfg_awvalid(i_cfg_awvalid),
		.o_cfg_awready(o_cfg_awready), .i_cfg_wdata(i_cfg_wdata),
		.i_cfg_wstrb(i_cfg_wstrb), .i_cfg_wvalid(i_cfg_wvalid),
		.o_cfg_wready(o_cfg_wready), .o_cfg_bresp(o_cfg_bresp),
		.o_cfg_bvalid(o_cfg_bvalid), .i_cfg_bready(i_cfg_bready),
		.i_cfg_araddr(i_cfg_araddr), .i_cfg_arvalid(i_cfg_arvalid),
		.o_cfg_arready(o_cfg_arready), .o_cfg_rdata(o_cfg_rdata),
		.o_cfg_rresp(o_cfg_rresp), .o_cfg_rvalid(o_cfg_rvalid),
		.i_cfg_rready(i_cfg_rready),
		.i_awr_cnt(awr_cnt), .i_wr_cnt(wr_cnt), .i_rd_cnt(rd_cnt),
		.i_viol_cnt(viol_cnt), .i_viol_stall(viol_stall), .i_viol_stab(viol_stab),
		.o_enable(enable), .o_req_limit(req_limit), .o_resp_limit(resp_limit),
		.o_delay_limit(delay_limit), .o_viol_any(o_viol_any)
	);

endmodule

/* tb/axil_mon_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the AXI4-Lite protocol monitor
// Monitored bus master and slave, configuration master, LFSR stimulus
// Immediate assertions on register readback and cycle timeout
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module axil_mon_tb;
	import axil_mon_pkg::*;

	// Galois LFSR taps for x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	localparam logic [31:0] LFSR_SEED = 32'd76420;
	// Cycle bound well above the length of the full sequence
	localparam int MAX_CYCLES = 3000;

	logic        i_clk;
	logic        i_axi_reset_n;
	logic [27:0] i_mon_awaddr, i_mon_araddr;
	logic [31:0] i_mon_wdata, i_mon_rdata;
	logic [3:0]  i_mon_wstrb;
	logic        i_mon_awvalid, i_mon_awready, i_mon_wvalid, i_mon_wready;
	logic        i_mon_bvalid, i_mon_bready, i_mon_arvalid, i_mon_arready;
	logic        i_mon_rvalid, i_mon_rready;
	resp_t       i_mon_bresp, i_mon_rresp;
	cfg_addr_t   i_cfg_awaddr, i_cfg_araddr;
	cfg_data_t   i_cfg_wdata;
	logic [3:0]  i_cfg_wstrb;
	logic        i_cfg_awvalid, i_cfg_wvalid, i_cfg_bready, i_cfg_arvalid, i_cfg_rready;
	logic        o_cfg_awready, o_cfg_wready, o_cfg_bvalid, o_cfg_arready, o_cfg_rvalid;
	resp_t       o_cfg_bresp, o_cfg_rresp;
	cfg_data_t   o_cfg_rdata;
	logic        o_viol_any;

	logic [31:0] lfsr_state;
	int          cycle_cnt = 0;
	logic [27:0] addr;
	logic [31:0] data;

	axil_mon_top UUT (.*);

	// 8 ns clock
	initial
		i_clk = 1'b0;
	always #4 i_clk = ~i_clk;

	// Run limit
	always @(posedge i_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("test failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	// Step once per bit and collect the bits shifted out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		logic        lsb;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ LFSR_TAPS;
			bits = {bits[30:0], lsb};
		end
		return bits;
	endfunction

	function automatic logic [27:0] rand_addr();
		logic [31:0] r;
		r = take_bits(28);
		return r[27:0];
	endfunction

	// Ready delay of 0 to 3 cycles stays well under the default limit
	function automatic int rand_delay();
		return int'(take_bits(2));
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		assert (actual === expected)
		else
		begin
			$display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Configuration master tasks start and end on a falling edge
	//////////////////////////////////////////////////////////////////////
	task automatic cfg_write(input cfg_addr_t a, input cfg_data_t d);
		i_cfg_awaddr  = a;
		i_cfg_wdata   = d;
		i_cfg_wstrb   = 4'hF;
		i_cfg_awvalid = 1'b1;
		i_cfg_wvalid  = 1'b1;
		i_cfg_bready  = 1'b1;
		do
			@(negedge i_clk);
		while (!o_cfg_awready);
		check_value({31'b0, o_cfg_wready}, 32'h1, "cfg wready with awready");
		@(negedge i_clk);
		i_cfg_awvalid = 1'b0;
		i_cfg_wvalid  = 1'b0;
		check_value({31'b0, o_cfg_bvalid}, 32'h1, "cfg bvalid after write");
		check_value({30'b0, o_cfg_bresp}, 32'h0, "cfg bresp");
		while (o_cfg_bvalid)
			@(negedge i_clk);
		i_cfg_bready = 1'b0;
	endtask

	task automatic cfg_read(input cfg_addr_t a, output cfg_data_t d);
		int dly;
		dly = rand_delay();
		i_cfg_araddr  = a;
		i_cfg_arvalid = 1'b1;
		do
			@(negedge i_clk);
		while (!o_cfg_arready);
		@(negedge i_clk);
		i_cfg_arvalid = 1'b0;
		while (!o_cfg_rvalid)
			@(negedge i_clk);
		d = o_cfg_rdata;
		check_value({30'b0, o_cfg_rresp}, 32'h0, "cfg rresp");
		// Master holds off rready for a while
		repeat (dly)
			@(negedge i_clk);
		i_cfg_rready = 1'b1;
		@(negedge i_clk);
		i_cfg_rready = 1'b0;
	endtask

	task automatic check_reg(input cfg_addr_t a, input logic [31:0] expected,
		input string what);
		cfg_data_t d;
		cfg_read(a, d);
		check_value(d, expected, what);
	endtask

	// Sticky bits land two cycles late and clear by writing ones
	task automatic expect_status(input logic [31:0] expected, input string what);
		repeat (4)
			@(negedge i_clk);
		check_reg(REG_STATUS, expected, what);
		check_value({31'b0, o_viol_any}, {31'b0, expected != 0}, "o_viol_any while set");
		cfg_write(REG_STATUS, expected);
		check_reg(REG_STATUS, 32'h0, "STATUS after clear");
		check_value({31'b0, o_viol_any}, 32'h0, "o_viol_any after clear");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitored bus master and slave
	//////////////////////////////////////////////////////////////////////
	task automatic mon_aw_w(input logic [27:0] a, input logic [31:0] d, input int stall);
		i_mon_awaddr  = a;
		i_mon_wdata   = d;
		i_mon_wstrb   = 4'hF;
		i_mon_awvalid = 1'b1;
		i_mon_wvalid  = 1'b1;
		repeat (stall)
			@(negedge i_clk);
		i_mon_awready = 1'b1;
		i_mon_wready  = 1'b1;
		@(negedge i_clk);
		{i_mon_awvalid, i_mon_wvalid, i_mon_awready, i_mon_wready} = 4'b0;
	endtask

	task automatic mon_ar(input logic [27:0] a, input int stall);
		i_mon_araddr  = a;
		i_mon_arvalid = 1'b1;
		repeat (stall)
			@(negedge i_clk);
		i_mon_arready = 1'b1;
		@(negedge i_clk);
		i_mon_arvalid = 1'b0;
		i_mon_arready = 1'b0;
	endtask

	task automatic mon_b(input resp_t r, input int stall);
		i_mon_bresp  = r;
		i_mon_bvalid = 1'b1;
		repeat (stall)
			@(negedge i_clk);
		i_mon_bready = 1'b1;
		@(negedge i_clk);
		i_mon_bvalid = 1'b0;
		i_mon_bready = 1'b0;
	endtask

	task automatic mon_r(input logic [31:0] d, input resp_t r, input int stall);
		i_mon_rdata  = d;
		i_mon_rresp  = r;
		i_mon_rvalid = 1'b1;
		repeat (stall)
			@(negedge i_clk);
		i_mon_rready = 1'b1;
		@(negedge i_clk);
		i_mon_rvalid = 1'b0;
		i_mon_rready = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		lfsr_state    = LFSR_SEED;
		i_axi_reset_n = 1'b0;
		{i_mon_awaddr, i_mon_araddr, i_mon_wdata, i_mon_rdata, i_mon_wstrb} = '0;
		{i_mon_awvalid, i_mon_awready, i_mon_wvalid, i_mon_wready} = 4'b0;
		{i_mon_bvalid, i_mon_bready, i_mon_arvalid, i_mon_arready} = 4'b0;
		{i_mon_rvalid, i_mon_rready, i_mon_bresp, i_mon_rresp} = '0;
		{i_cfg_awaddr, i_cfg_araddr, i_cfg_wdata, i_cfg_wstrb} = '0;
		{i_cfg_awvalid, i_cfg_wvalid, i_cfg_bready, i_cfg_arvalid, i_cfg_rready} = 5'b0;
		repeat (4)
			@(negedge i_clk);
		i_axi_reset_n = 1'b1;

		// Reset values
		check_value({27'b0, o_cfg_awready, o_cfg_wready, o_cfg_bvalid, o_cfg_arready,
			o_cfg_rvalid}, 32'h0, "cfg handshake outputs after reset");
		check_value({31'b0, o_viol_any}, 32'h0, "o_viol_any after reset");
		check_reg(REG_CTRL, 32'h1, "CTRL after reset");
		check_reg(REG_LIMITS, 32'h00080808, "LIMITS after reset");
		check_reg(REG_STATUS, 32'h0, "STATUS after reset");
		check_reg(REG_COUNTS, 32'h0, "COUNTS after reset");

		// Clean traffic with short ready delays
		for (int n = 0; n < 8; n++)
		begin
			mon_aw_w(rand_addr(), take_bits(32), rand_delay());
			mon_b(RESP_OKAY, rand_delay());
			mon_ar(rand_addr(), rand_delay());
			mon_r(take_bits(32), RESP_OKAY, rand_delay());
		end
		repeat (4)
			@(negedge i_clk);
		check_reg(REG_STATUS, 32'h0, "STATUS after clean traffic");

		// One write and one read in flight
		addr = rand_addr();
		data = take_bits(32);
		mon_aw_w(addr, data, 0);
		mon_ar(addr, 0);
		check_reg(REG_COUNTS, 32'h111, "COUNTS with one of each outstanding");
		mon_b(RESP_OKAY, 0);
		mon_r(data, RESP_OKAY, 0);
		check_reg(REG_COUNTS, 32'h0, "COUNTS after responses");
		// Latency bits may have fired while the counts were read
		cfg_write(REG_STATUS, 32'hFFF);
		check_reg(REG_STATUS, 32'h0, "STATUS after full clear");

		// AR held 12 cycles against a limit of 8
		mon_ar(rand_addr(), 12);
		mon_r(take_bits(32), RESP_OKAY, 0);
		expect_status(32'h1 << VIOL_AR_STALL, "STATUS after AR stall");

		// AW and W stalled together so both timers run
		mon_aw_w(rand_addr(), take_bits(32), 12);
		mon_b(RESP_OKAY, 0);
		expect_status((32'h1 << VIOL_AW_STALL) | (32'h1 << VIOL_W_STALL),
			"STATUS after AW stall");

		// Silent slave followed by a master that holds off rready
		mon_ar(rand_addr(), 0);
		repeat (12)
			@(negedge i_clk);
		mon_r(take_bits(32), RESP_OKAY, 12);
		expect_status((32'h1 << VIOL_RD_LAT) | (32'h1 << VIOL_R_STALL),
			"STATUS after read latency and R stall");

		// Zero limits switch the timers off
		cfg_write(REG_LIMITS, 32'h0);
		mon_ar(rand_addr(), 0);
		repeat (12)
			@(negedge i_clk);
		mon_r(take_bits(32), RESP_OKAY, 12);
		expect_status(32'h0, "STATUS with zero limits");
		cfg_write(REG_LIMITS, 32'h00080808);

		// AW valid dropped without a handshake
		i_mon_awaddr  = rand_addr();
		i_mon_awvalid = 1'b1;
		repeat (2)
			@(negedge i_clk);
		i_mon_awvalid = 1'b0;
		expect_status(32'h1 << VIOL_REQ_STAB, "STATUS after AW valid drop");

		// R data changes while stalled
		mon_ar(rand_addr(), 0);
		data = take_bits(32);
		i_mon_rdata  = data;
		i_mon_rresp  = RESP_OKAY;
		i_mon_rvalid = 1'b1;
		repeat (2)
			@(negedge i_clk);
		i_mon_rdata = ~data;
		@(negedge i_clk);
		i_mon_rready = 1'b1;
		@(negedge i_clk);
		i_mon_rvalid = 1'b0;
		i_mon_rready = 1'b0;
		expect_status(32'h1 << VIOL_RESP_STAB, "STATUS after R data change");

		// B with no write outstanding
		mon_b(RESP_OKAY, 0);
		expect_status(32'h1 << VIOL_ORPHAN, "STATUS after orphan B");
		check_reg(REG_COUNTS, 32'h0, "COUNTS after orphan B");

		// Exclusive-okay read response
		mon_ar(rand_addr(), 0);
		mon_r(take_bits(32), 2'b01, 0);
		expect_status(32'h1 << VIOL_EXOKAY, "STATUS after EXOKAY");

		// B stall ignored while the monitor is disabled
		cfg_write(REG_CTRL, 32'h0);
		check_reg(REG_CTRL, 32'h0, "CTRL after disable");
		mon_aw_w(rand_addr(), take_bits(32), 0);
		mon_b(RESP_OKAY, 12);
		expect_status(32'h0, "STATUS while disabled");
		cfg_write(REG_CTRL, 32'h1);

		// Sixteenth read hits a full 4-bit count with no R returned
		for (int n = 0; n < 16; n++)
			mon_ar(rand_addr(), 0);
		expect_status((32'h1 << VIOL_OVERFLOW) | (32'h1 << VIOL_RD_LAT),
			"STATUS after read overflow");
		check_reg(REG_COUNTS, 32'h00F, "COUNTS held at full");

		// Drain the fifteen counted reads
		for (int n = 0; n < 15; n++)
			mon_r(take_bits(32), RESP_OKAY, 0);
		check_reg(REG_COUNTS, 32'h0, "COUNTS after drain");
		repeat (4)
			@(negedge i_clk);
		check_reg(REG_STATUS, 32'h0, "STATUS after drain");

		$display("test passed");
		$finish;
	end

endmodule

/* axil_mon.f */
logic/axil_mon_pkg.sv
logic/axil_txn_counter.sv
logic/axil_stall_checker.sv
logic/axil_stability_checker.sv
logic/axil_mon_regs.sv
logic/axil_mon_top.sv
tb/axil_mon_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module axil_mon_tb -f axil_mon.f -o Vaxil_mon_tb

# The simulator exits nonzero on a fatal check; the log decides the result
./obj_dir/Vaxil_mon_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "test passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
